//--- hw/pc_cfr_pkg.sv
// Shared definitions for the CFR peak detection front end
// Holds the sample, polar, peak and control structs, the detector slope
// state and the AXI4-Lite register map. Struct widths follow the default
// DATA_WIDTH and ITERATIONS of the top level
package pc_cfr_pkg;

  // Default data path sizes, the top level takes its parameter defaults from these
  localparam int DEF_DATA_WIDTH = 16;
  localparam int DEF_ITERATIONS = 7;

  // Magnitude and thresholds carry one bit more than the I/Q words
  localparam int THR_WIDTH = DEF_DATA_WIDTH + 1;

  // CORDIC gain of 7 micro-rotations, about 1.6467 in Q15
  localparam int CORDIC_GAIN_Q15 = 53959;

  // ********************
  // AXI4-Lite
  // ********************
  localparam int AXI_ADDR_WIDTH = 4;
  localparam int AXI_DATA_WIDTH = 32;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [AXI_ADDR_WIDTH-1:0] {
    REG_CTRL     = 4'h0,
    REG_PD_THR   = 4'h4,
    REG_CLIP_THR = 4'h8
  } reg_addr_e;

  // ********************
  // Data path words
  // ********************
  typedef struct packed {
    logic signed [DEF_DATA_WIDTH-1:0] i;
    logic signed [DEF_DATA_WIDTH-1:0] q;
  } iq_t;

  // Two samples per clock, phase 0 is the earlier one
  typedef struct packed {
    iq_t p1;
    iq_t p0;
  } iq_pair_t;

  // Theta is a signed fraction of pi
  typedef struct packed {
    logic [DEF_DATA_WIDTH:0]        r;
    logic signed [DEF_ITERATIONS:0] theta;
  } polar_t;

  typedef struct packed {
    logic                           valid;
    logic [DEF_DATA_WIDTH:0]        r;
    logic signed [DEF_ITERATIONS:0] theta;
    logic                           phase;
  } peak_t;

  typedef enum logic {
    S_NEG,
    S_POS
  } pd_state_e;

  typedef struct packed {
    logic                 enable;
    logic [THR_WIDTH-1:0] pd_threshold;
    logic [THR_WIDTH-1:0] clipping_threshold;
  } cfr_ctrl_t;

endpackage

//--- hw/pc_cfr_cordic.sv
// Pipelined CORDIC vectoring lane
// Turns one rectangular I/Q sample per clock into magnitude and angle.
// One quadrant stage, ITERATIONS rotation stages and an output register
// give a fixed latency of ITERATIONS+2 cycles
`timescale 1ns/1ps

module pc_cfr_cordic
  import pc_cfr_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int ITERATIONS = 7
) (
  input  logic   clk,
  input  logic   rst,
  input  iq_t    sample,
  output polar_t polar
);

  // Two guard bits hold the negated full scale value and the CORDIC gain
  localparam int XW = DATA_WIDTH + 2;
  // Angle accumulator runs with pi at 2^15 and wraps at 2 pi
  localparam int ZW = 16;
  localparam int ZSHIFT = ZW - 1 - ITERATIONS;
  localparam logic signed [ZW-1:0] Z_PI = {1'b1, {(ZW-1){1'b0}}};
  localparam logic signed [ZW-1:0] Z_HALF = ZW'(1 << (ZSHIFT - 1));

  logic signed [XW-1:0] i_ext;
  logic signed [XW-1:0] q_ext;
  logic signed [XW-1:0] x_q[ITERATIONS+1];
  logic signed [XW-1:0] y_q[ITERATIONS+1];
  logic signed [ZW-1:0] z_q[ITERATIONS+1];
  logic signed [ZW-1:0] z_round;

  // atan(2^-k) in units where pi is 2^15
  function automatic logic signed [ZW-1:0] atan_lut(input int k);
    case (k)
      0:       return 16'sd8192;
      1:       return 16'sd4836;
      2:       return 16'sd2555;
      3:       return 16'sd1297;
      4:       return 16'sd651;
      5:       return 16'sd326;
      6:       return 16'sd163;
      7:       return 16'sd81;
      8:       return 16'sd41;
      9:       return 16'sd20;
      10:      return 16'sd10;
      11:      return 16'sd5;
      12:      return 16'sd3;
      13:      return 16'sd1;
      14:      return 16'sd1;
      default: return 16'sd0;
    endcase
  endfunction

  assign i_ext = XW'(sample.i);
  assign q_ext = XW'(sample.q);

  // ********************
  // Rotation pipeline
  // ********************
  always_ff @(posedge clk) begin
    // Left half-plane vectors are mirrored through the origin
    // The pi offset is the same as -pi once the accumulator wraps
    if (i_ext[XW-1]) begin
      x_q[0] <= -i_ext;
      y_q[0] <= -q_ext;
      z_q[0] <= Z_PI;
    end else begin
      x_q[0] <= i_ext;
      y_q[0] <= q_ext;
      z_q[0] <= '0;
    end
    // Each stage drives y toward zero and adds up the angle it turned by
    for (int k = 0; k < ITERATIONS; k++) begin
      if (!y_q[k][XW-1]) begin
        x_q[k+1] <= x_q[k] + (y_q[k] >>> k);
        y_q[k+1] <= y_q[k] - (x_q[k] >>> k);
        z_q[k+1] <= z_q[k] + atan_lut(k);
      end else begin
        x_q[k+1] <= x_q[k] - (y_q[k] >>> k);
        y_q[k+1] <= y_q[k] + (x_q[k] >>> k);
        z_q[k+1] <= z_q[k] - atan_lut(k);
      end
    end
  end

  // Round the accumulator to ITERATIONS+1 bits, a carry past +pi wraps to -pi
  assign z_round = z_q[ITERATIONS] + Z_HALF;

  // ********************
  // Output register
  // ********************
  // Final x is never negative, it is the magnitude times CORDIC_GAIN_Q15
  always_ff @(posedge clk) begin
    if (rst) begin
      polar <= '0;
    end else begin
      polar.r     <= x_q[ITERATIONS][DATA_WIDTH:0];
      polar.theta <= z_round[ZW-1:ZSHIFT];
    end
  end

endmodule

//--- hw/pc_cfr_pd.sv
// Two-phase peak detector
// Finds local magnitude maxima across the interleaved two-phase stream,
// keeps those above the detection threshold and reports the excess over
// the clipping threshold with the angle and phase of the peak sample.
// Latency is 4 cycles from the pair after the peak pair to peak.valid
`timescale 1ns/1ps

module pc_cfr_pd
  import pc_cfr_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int ITERATIONS = 7
) (
  input  logic      clk,
  input  logic      rst,
  input  polar_t    polar_p0,
  input  polar_t    polar_p1,
  input  cfr_ctrl_t ctrl,
  output peak_t     peak
);

  // Stage 1 holds the current pair and its larger sample
  logic [DATA_WIDTH:0]        s1_r0;
  logic [DATA_WIDTH:0]        s1_r1;
  logic [DATA_WIDTH:0]        s1_big_r;
  logic signed [ITERATIONS:0] s1_big_theta;
  logic                       s1_big_phase;

  // Larger sample of the previous pair, the candidate peak
  logic [DATA_WIDTH:0]        hold_r;
  logic signed [ITERATIONS:0] hold_theta;
  logic                       hold_phase;

  logic [DATA_WIDTH:0]        det_r;
  logic signed [ITERATIONS:0] det_theta;
  logic                       det_phase;
  logic                       det_valid;

  logic [DATA_WIDTH:0]        qual_r;
  logic signed [ITERATIONS:0] qual_theta;
  logic                       qual_phase;
  logic                       qual_valid;

  pd_state_e                  state_q;
  logic                       pick_p1;
  logic                       rise;

  // Ties go to phase 1
  assign pick_p1 = polar_p1.r >= polar_p0.r;

  // The slope still rises if either sample of the pair reaches the held maximum
  assign rise = (s1_r0 >= hold_r) || (s1_r1 >= hold_r);

  // ********************
  // History
  // ********************
  always_ff @(posedge clk) begin
    s1_r0        <= polar_p0.r;
    s1_r1        <= polar_p1.r;
    s1_big_r     <= pick_p1 ? polar_p1.r : polar_p0.r;
    s1_big_theta <= pick_p1 ? polar_p1.theta : polar_p0.theta;
    s1_big_phase <= pick_p1;
    hold_r       <= s1_big_r;
    hold_theta   <= s1_big_theta;
    hold_phase   <= s1_big_phase;
  end

  // ********************
  // Detection and qualification
  // ********************
  // A peak is the held sample when the slope was rising and the new pair
  // lies entirely below it
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_NEG;
      det_valid  <= 1'b0;
      qual_valid <= 1'b0;
    end else begin
      state_q    <= rise ? S_POS : S_NEG;
      det_valid  <= (state_q == S_POS) && !rise;
      qual_valid <= det_valid && ctrl.enable && (det_r > ctrl.pd_threshold);
    end
  end

  always_ff @(posedge clk) begin
    det_r      <= hold_r;
    det_theta  <= hold_theta;
    det_phase  <= hold_phase;
    // Excess over the clipping level is what the cancellation pulse removes
    qual_r     <= det_r - ctrl.clipping_threshold;
    qual_theta <= det_theta;
    qual_phase <= det_phase;
  end

  // Everything but a qualified peak leaves the block as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      peak <= '0;
    end else if (qual_valid) begin
      peak.valid <= 1'b1;
      peak.r     <= qual_r;
      peak.theta <= qual_theta;
      peak.phase <= qual_phase;
    end else begin
      peak <= '0;
    end
  end

endmodule

//--- hw/pc_cfr_regs.sv
// AXI4-Lite register block for the peak detector
// Holds the enable bit, the detection threshold and the clipping
// threshold. Offsets outside the map answer SLVERR
`timescale 1ns/1ps

module pc_cfr_regs
  import pc_cfr_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [AXI_DATA_WIDTH-1:0]   rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  output cfr_ctrl_t                   ctrl
);

  reg_addr_e                 wr_addr;
  reg_addr_e                 rd_addr;
  logic                      wr_hs;
  logic                      rd_hs;
  logic                      wr_ok;
  logic                      rd_ok;
  logic [AXI_DATA_WIDTH-1:0] wr_mask;
  logic [AXI_DATA_WIDTH-1:0] ctrl_word;
  logic [AXI_DATA_WIDTH-1:0] pd_word;
  logic [AXI_DATA_WIDTH-1:0] clip_word;
  logic [AXI_DATA_WIDTH-1:0] ctrl_wr;
  logic [AXI_DATA_WIDTH-1:0] pd_wr;
  logic [AXI_DATA_WIDTH-1:0] clip_wr;
  logic [AXI_DATA_WIDTH-1:0] rd_word;

  // Misaligned offsets miss the enum values and end up unmapped
  assign wr_addr = reg_addr_e'(awaddr);
  assign rd_addr = reg_addr_e'(araddr);

  // Both ready lines pulse together
  assign wready = awready;
  assign wr_hs  = awvalid && awready && wvalid && wready;
  assign rd_hs  = arvalid && arready;

  // Register contents as seen on the bus
  assign ctrl_word = {{(AXI_DATA_WIDTH-1){1'b0}}, ctrl.enable};
  assign pd_word   = {{(AXI_DATA_WIDTH-THR_WIDTH){1'b0}}, ctrl.pd_threshold};
  assign clip_word = {{(AXI_DATA_WIDTH-THR_WIDTH){1'b0}}, ctrl.clipping_threshold};

  always_comb begin
    for (int b = 0; b < AXI_DATA_WIDTH / 8; b++) begin
      wr_mask[8*b +: 8] = {8{wstrb[b]}};
    end
  end

  // Bytes without a strobe keep their old value
  assign ctrl_wr = (ctrl_word & ~wr_mask) | (wdata & wr_mask);
  assign pd_wr   = (pd_word & ~wr_mask) | (wdata & wr_mask);
  assign clip_wr = (clip_word & ~wr_mask) | (wdata & wr_mask);

  // ********************
  // Address decode
  // ********************
  always_comb begin
    case (wr_addr)
      REG_CTRL, REG_PD_THR, REG_CLIP_THR: wr_ok = 1'b1;
      default:                            wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_ok   = 1'b1;
    case (rd_addr)
      REG_CTRL:     rd_word = ctrl_word;
      REG_PD_THR:   rd_word = pd_word;
      REG_CLIP_THR: rd_word = clip_word;
      default:      rd_ok = 1'b0;
    endcase
  end

  // ********************
  // Registers
  // ********************
  // The new value is live on the cycle after the AW/W handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.enable             <= 1'b0;
      ctrl.pd_threshold       <= '1;
      ctrl.clipping_threshold <= '0;
    end else if (wr_hs) begin
      case (wr_addr)
        REG_CTRL:     ctrl.enable <= ctrl_wr[0];
        REG_PD_THR:   ctrl.pd_threshold <= pd_wr[THR_WIDTH-1:0];
        REG_CLIP_THR: ctrl.clipping_threshold <= clip_wr[THR_WIDTH-1:0];
        default:      ctrl.enable <= ctrl.enable;
      endcase
    end
  end

  // ********************
  // Handshakes
  // ********************
  // A new write or read is taken only once the previous response is gone
  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      awready <= !awready && !bvalid && awvalid && wvalid;
      arready <= !arready && !rvalid && arvalid;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      rdata <= rd_word;
      rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

//--- hw/pc_cfr_detect.sv
// Peak detection front end of the peak-cancellation CFR
// Two CORDIC lanes convert phase 0 and phase 1 to polar form, the peak
// detector combines them, and an AXI4-Lite block holds its settings
`timescale 1ns/1ps

module pc_cfr_detect
  import pc_cfr_pkg::*;
#(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int ITERATIONS = DEF_ITERATIONS
) (
  input  logic                        clk,
  input  logic                        rst,
  // AXI4-Lite configuration slave
  input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [AXI_DATA_WIDTH-1:0]   wdata,
  input  logic [AXI_DATA_WIDTH/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [AXI_DATA_WIDTH-1:0]   rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,
  // Free-running sample stream, no handshake
  input  iq_pair_t                    samples,
  output peak_t                       peak
);

  polar_t    polar_p0;
  polar_t    polar_p1;
  cfr_ctrl_t ctrl;

  // ********************
  // CORDIC lanes
  // ********************
  pc_cfr_cordic #(
    .DATA_WIDTH(DATA_WIDTH),
    .ITERATIONS(ITERATIONS)
  ) u_cordic_p0 (
    .clk   (clk),
    .rst   (rst),
    .sample(samples.p0),
    .polar (polar_p0)
  );

  pc_cfr_cordic #(
    .DATA_WIDTH(DATA_WIDTH),
    .ITERATIONS(ITERATIONS)
  ) u_cordic_p1 (
    .clk   (clk),
    .rst   (rst),
    .sample(samples.p1),
    .polar (polar_p1)
  );

  // ********************
  // Detector and registers
  // ********************
  pc_cfr_pd #(
    .DATA_WIDTH(DATA_WIDTH),
    .ITERATIONS(ITERATIONS)
  ) u_pd (
    .clk     (clk),
    .rst     (rst),
    .polar_p0(polar_p0),
    .polar_p1(polar_p1),
    .ctrl    (ctrl),
    .peak    (peak)
  );

  pc_cfr_regs u_regs (
    .clk    (clk),
    .rst    (rst),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .ctrl   (ctrl)
  );

endmodule

//--- sim/tb_pc_cfr_detect.sv
// Testbench for the CFR peak detection front end
// Configures the AXI4-Lite registers, sends isolated pulses through the
// two-phase sample stream and checks each peak window against a polar
// model of the pulse built from real arithmetic
`timescale 1ns/1ps

module tb_pc_cfr_detect
  import pc_cfr_pkg::*;
();

  localparam int ITER = DEF_ITERATIONS;
  localparam int WINDOW = 40;
  localparam int RESET_CYCLES = 10;
  // 1 + 6 + 8 + 3 + 5 + 4 windows over the six tests
  localparam int NUM_WINDOWS = 27;
  localparam int NUM_AXI_OPS = 12;
  localparam int AXI_OP_CYCLES = 8;
  localparam int TIMEOUT_CYCLES =
    (RESET_CYCLES + NUM_WINDOWS * WINDOW + NUM_AXI_OPS * AXI_OP_CYCLES) * 3 / 2;
  localparam int MAG_TOL = ITER + 2;
  localparam int THETA_TOL = 2;
  localparam int PD_THR = 15000;
  localparam int CLIP_THR = 12000;
  localparam real PI = 3.14159265358979;

  logic                        clk;
  logic                        rst;
  logic [AXI_ADDR_WIDTH-1:0]   awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [AXI_DATA_WIDTH-1:0]   wdata;
  logic [AXI_DATA_WIDTH/8-1:0] wstrb;
  logic                        wvalid;
  logic                        wready;
  logic [1:0]                  bresp;
  logic                        bvalid;
  logic                        bready;
  logic [AXI_ADDR_WIDTH-1:0]   araddr;
  logic                        arvalid;
  logic                        arready;
  logic [AXI_DATA_WIDTH-1:0]   rdata;
  logic [1:0]                  rresp;
  logic                        rvalid;
  logic                        rready;
  iq_pair_t                    samples;
  peak_t                       peak;

  int cur_errors;
  int pass_count;
  int fail_count;
  int cycle_count;

  pc_cfr_detect u_pc_cfr_detect (
    .clk    (clk),
    .rst    (rst),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .samples(samples),
    .peak   (peak)
  );

  always #50 clk = ~clk;

  // Run limit, about half again the length of all windows and bus accesses
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a test never finished", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // A peak word that is not valid must be all zero
  idle_peak_zero: assert property (@(posedge clk) disable iff (rst)
    !peak.valid |-> (peak == '0))
  else begin
    $display("Peak output carries data at %0t while peak.valid is low", $time);
    cur_errors++;
  end

  // Write address and write data are accepted on the same cycle
  ready_pair: assert property (@(posedge clk) disable iff (rst) awready == wready)
  else begin
    $display("awready and wready differ at %0t", $time);
    cur_errors++;
  end

  // ********************
  // Reference model
  // ********************
  // Magnitude after the CORDIC gain, rounded to the nearest LSB
  function automatic int scaled_mag(input int i, input int q);
    real a;
    a = $sqrt(real'(i) * real'(i) + real'(q) * real'(q));
    return int'(a * real'(CORDIC_GAIN_Q15) / 32768.0);
  endfunction

  // Angle in units of pi / 2^ITER, +pi folds onto -pi
  function automatic int expected_theta(input int i, input int q);
    real t;
    int  v;
    t = $atan2(real'(q), real'(i)) / PI * real'(2 ** ITER);
    v = int'(t);
    if (v >= 2 ** ITER) begin
      v -= 2 ** (ITER + 1);
    end
    return v;
  endfunction

  // Distance between two angles around the circle
  function automatic int theta_distance(input int a, input int b);
    int d;
    d = a - b;
    while (d >= 2 ** ITER) d -= 2 ** (ITER + 1);
    while (d < -(2 ** ITER)) d += 2 ** (ITER + 1);
    return (d < 0) ? -d : d;
  endfunction

  function automatic iq_t make_iq(input int i, input int q);
    iq_t s;
    s.i = DEF_DATA_WIDTH'(i);
    s.q = DEF_DATA_WIDTH'(q);
    return s;
  endfunction

  // Pulse on one phase, the other phase of the pair stays zero
  function automatic iq_pair_t place_pulse(input int i, input int q, input bit phase);
    iq_pair_t pair;
    pair = '0;
    if (phase) begin
      pair.p1 = make_iq(i, q);
    end else begin
      pair.p0 = make_iq(i, q);
    end
    return pair;
  endfunction

  // Random amplitude and angle, quad below zero means any direction
  task automatic random_pulse(input int amp_lo, input int amp_hi, input int quad,
                              output int i, output int q);
    int  amp;
    int  deg;
    real rad;
    amp = int'($urandom_range(amp_hi, amp_lo));
    if (quad < 0) begin
      deg = int'($urandom_range(359, 0));
    end else begin
      deg = quad * 90 + int'($urandom_range(80, 10));
    end
    rad = real'(deg) * PI / 180.0;
    i = int'(real'(amp) * $cos(rad));
    q = int'(real'(amp) * $sin(rad));
  endtask

  // ********************
  // Check helpers
  // ********************
  task automatic compare_value(input string name, input int expected, input int actual);
    assert (expected == actual)
    else begin
      $display("MISMATCH t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected,
               actual);
      cur_errors++;
    end
  endtask

  task automatic close_test(input string name);
    if (cur_errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", name, cur_errors);
    end
    cur_errors = 0;
  endtask

  // Write handshake: both valids up, wait for the ready pulse, then the response
  task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr, input int data,
                           output logic [1:0] resp);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = AXI_DATA_WIDTH'(data);
    wstrb   = '1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(posedge clk);
    #1;
    while (!(awready && wready)) begin
      @(posedge clk);
      #1;
    end
    // The handshake edge has now passed
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr, output int data,
                          output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(posedge clk);
    #1;
    while (!arready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    data = int'(rdata);
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // One window: two driven pairs, then zeros, while every peak is counted
  task automatic run_window(input iq_pair_t first, input iq_pair_t second,
                            input bit expect_peak, input bit exp_phase,
                            input int exp_r, input int exp_theta);
    int    hits;
    peak_t seen;
    hits = 0;
    seen = '0;
    for (int c = 0; c < WINDOW; c++) begin
      @(posedge clk);
      #1;
      if (c == 0) begin
        samples = first;
      end else if (c == 1) begin
        samples = second;
      end else begin
        samples = '0;
      end
      if (peak.valid) begin
        hits++;
        seen = peak;
      end
    end
    assert (hits == (expect_peak ? 1 : 0))
    else begin
      $display("MISMATCH t=%0t peak.valid count expected %0d actual %0d", $time,
               expect_peak ? 1 : 0, hits);
      cur_errors++;
    end
    if (expect_peak && hits == 1) begin
      assert ((int'(seen.r) - exp_r <= MAG_TOL) && (exp_r - int'(seen.r) <= MAG_TOL))
      else begin
        $display("MISMATCH t=%0t peak.r expected %0d actual %0d", $time, exp_r,
                 int'(seen.r));
        cur_errors++;
      end
      assert (theta_distance(int'($signed(seen.theta)), exp_theta) <= THETA_TOL)
      else begin
        $display("MISMATCH t=%0t peak.theta expected %0d actual %0d", $time, exp_theta,
                 int'($signed(seen.theta)));
        cur_errors++;
      end
      assert (seen.phase == exp_phase)
      else begin
        $display("MISMATCH t=%0t peak.phase expected %0d actual %0d", $time, exp_phase,
                 seen.phase);
        cur_errors++;
      end
    end
  endtask

  // ********************
  // Test sequence
  // ********************
  initial begin
    int         i;
    int         q;
    int         data;
    bit         ph;
    logic [1:0] resp;
    iq_pair_t   pair;
    iq_pair_t   pair_b;

    clk         = 1'b0;
    rst         = 1'b1;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    samples     = '0;
    cur_errors  = 0;
    pass_count  = 0;
    fail_count  = 0;
    void'($urandom(61));

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Handshake outputs and the peak flag come out of reset low
    compare_value("awready", 0, int'(awready));
    compare_value("wready", 0, int'(wready));
    compare_value("arready", 0, int'(arready));
    compare_value("bvalid", 0, int'(bvalid));
    compare_value("rvalid", 0, int'(rvalid));
    compare_value("peak.valid", 0, int'(peak.valid));

    // Reset values, threshold write and read back, unmapped offset
    run_window('0, '0, 1'b0, 1'b0, 0, 0);
    axi_read(REG_CTRL, data, resp);
    compare_value("ctrl reset", 0, data);
    compare_value("rresp", int'(RESP_OKAY), int'(resp));
    axi_read(REG_PD_THR, data, resp);
    compare_value("pd threshold reset", 2 ** THR_WIDTH - 1, data);
    axi_read(REG_CLIP_THR, data, resp);
    compare_value("clipping threshold reset", 0, data);
    axi_write(REG_PD_THR, PD_THR, resp);
    compare_value("bresp", int'(RESP_OKAY), int'(resp));
    axi_read(REG_PD_THR, data, resp);
    compare_value("pd threshold", PD_THR, data);
    axi_write(REG_CLIP_THR, CLIP_THR, resp);
    compare_value("bresp", int'(RESP_OKAY), int'(resp));
    axi_read(REG_CLIP_THR, data, resp);
    compare_value("clipping threshold", CLIP_THR, data);
    axi_write(4'hC, 1, resp);
    compare_value("bresp unmapped", int'(RESP_SLVERR), int'(resp));
    axi_read(4'hC, data, resp);
    compare_value("rresp unmapped", int'(RESP_SLVERR), int'(resp));
    close_test("reset and registers");

    // Isolated pulses on a random phase
    axi_write(REG_CTRL, 1, resp);
    for (int n = 0; n < 6; n++) begin
      random_pulse(12000, 28000, -1, i, q);
      ph = 1'($urandom_range(1, 0));
      run_window(place_pulse(i, q, ph), '0, 1'b1, ph, scaled_mag(i, q) - CLIP_THR,
                 expected_theta(i, q));
    end
    close_test("single peak");

    // Two pulses in each quadrant
    for (int n = 0; n < 8; n++) begin
      random_pulse(12000, 28000, n / 2, i, q);
      ph = 1'($urandom_range(1, 0));
      run_window(place_pulse(i, q, ph), '0, 1'b1, ph, scaled_mag(i, q) - CLIP_THR,
                 expected_theta(i, q));
    end
    close_test("angle");

    // Scaled magnitude stays well under the detection threshold
    for (int n = 0; n < 3; n++) begin
      random_pulse(4000, 8000, -1, i, q);
      ph = 1'($urandom_range(1, 0));
      run_window(place_pulse(i, q, ph), '0, 1'b0, ph, 0, 0);
    end
    close_test("detection threshold");

    axi_write(REG_CTRL, 0, resp);
    for (int n = 0; n < 3; n++) begin
      random_pulse(12000, 28000, -1, i, q);
      ph = 1'($urandom_range(1, 0));
      run_window(place_pulse(i, q, ph), '0, 1'b0, ph, 0, 0);
    end
    axi_write(REG_CTRL, 1, resp);
    for (int n = 0; n < 2; n++) begin
      random_pulse(12000, 28000, -1, i, q);
      ph = 1'($urandom_range(1, 0));
      run_window(place_pulse(i, q, ph), '0, 1'b1, ph, scaled_mag(i, q) - CLIP_THR,
                 expected_theta(i, q));
    end
    close_test("disable");

    // Equal samples on both phases go to phase 1
    for (int n = 0; n < 2; n++) begin
      random_pulse(12000, 28000, -1, i, q);
      pair.p0 = make_iq(i, q);
      pair.p1 = make_iq(i, q);
      run_window(pair, '0, 1'b1, 1'b1, scaled_mag(i, q) - CLIP_THR, expected_theta(i, q));
    end
    // Rising over one pair and falling over the next, the largest is on phase 0
    for (int n = 0; n < 2; n++) begin
      random_pulse(16000, 28000, -1, i, q);
      pair.p0   = make_iq(i * 3 / 10, q * 3 / 10);
      pair.p1   = make_iq(i * 6 / 10, q * 6 / 10);
      pair_b.p0 = make_iq(i, q);
      pair_b.p1 = make_iq(i / 2, q / 2);
      run_window(pair, pair_b, 1'b1, 1'b0, scaled_mag(i, q) - CLIP_THR,
                 expected_theta(i, q));
    end
    close_test("pulse on both phases");

    $display("Tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- files.f
hw/pc_cfr_pkg.sv
hw/pc_cfr_cordic.sv
hw/pc_cfr_pd.sv
hw/pc_cfr_regs.sv
hw/pc_cfr_detect.sv
sim/tb_pc_cfr_detect.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f files.f --top-module tb_pc_cfr_detect -Mdir obj_dir

./obj_dir/Vtb_pc_cfr_detect > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"
